// ==== hw/periph_params.svh ====
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// Peripheral IDs in address bits 15..8
`define PERIPH_PWM_ID  8'h02
`define PERIPH_GPIO_ID 8'h03

// Pad count
`define IO_PADS 16

// PWM channels, mapped onto pads PWM_PAD_BASE and up
`define PWM_CHANNELS 4
`define PWM_PAD_BASE 12

`endif

// ==== hw/periph_pkg.sv ====
package periph_pkg;

	// Bridge sequencing, one request in flight
	typedef enum logic [1:0] {
		IDLE,
		STROBE,
		RESPOND
	} bridge_state_e;

	// GPIO word offsets
	typedef enum logic [7:0] {
		GPIO_OUT    = 8'd0,
		GPIO_OE     = 8'd1,
		GPIO_IN     = 8'd2,	// Read only
		GPIO_TOGGLE = 8'd3	// Write only, reads as zero
	} gpio_reg_e;

	// PWM word offsets
	typedef enum logic [7:0] {
		PWM_ENABLE = 8'd0,
		PWM_PERIOD = 8'd1,
		PWM_DUTY0  = 8'd2,
		PWM_DUTY1  = 8'd3,
		PWM_DUTY2  = 8'd4,
		PWM_DUTY3  = 8'd5
	} pwm_reg_e;

endpackage

// ==== hw/wb_periph_bridge.sv ====
`timescale 1ns/10ps

module wb_periph_bridge (
		input  logic        wb_clk_i,
		input  logic        reset_i,
		input  logic        wb_cyc_i,
		input  logic        wb_stb_i,
		input  logic        wb_we_i,
		input  logic [3:0]  wb_sel_i,
		input  logic [23:0] wb_adr_i,
		input  logic [31:0] wb_data_i,
		output logic        wb_ack_o,
		output logic        wb_error_o,
		output logic        wb_stall_o,
		output logic [31:0] wb_data_o,
		output logic        bus_we_o,
		output logic        bus_oe_o,
		output logic [23:0] bus_address_o,
		output logic [3:0]  bus_byte_select_o,
		output logic [31:0] bus_data_write_o,
		input  logic [31:0] bus_data_read_i,
		input  logic        bus_hit_i
	);

	periph_pkg::bridge_state_e state_q;

	assign wb_stall_o = (state_q != periph_pkg::IDLE);	// Busy from accept to response

	// Request fields are held until the response goes out
	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			bus_address_o     <= 24'h0;
			bus_byte_select_o <= 4'h0;
			bus_data_write_o  <= 32'h0;
		end else if (state_q == periph_pkg::IDLE && wb_cyc_i && wb_stb_i) begin
			bus_address_o     <= wb_adr_i;
			bus_byte_select_o <= wb_sel_i;
			bus_data_write_o  <= wb_data_i;
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			state_q    <= periph_pkg::IDLE;
			bus_we_o   <= 1'b0;
			bus_oe_o   <= 1'b0;
			wb_ack_o   <= 1'b0;
			wb_error_o <= 1'b0;
			wb_data_o  <= 32'h0;
		end else begin
			case (state_q)
				periph_pkg::IDLE: begin
					if (wb_cyc_i && wb_stb_i) begin
						bus_we_o <= wb_we_i;
						bus_oe_o <= !wb_we_i;
						state_q  <= periph_pkg::STROBE;
					end
				end
				periph_pkg::STROBE: begin
					// Peripherals answer within the strobe cycle
					bus_we_o   <= 1'b0;
					bus_oe_o   <= 1'b0;
					wb_ack_o   <= bus_hit_i;
					wb_error_o <= !bus_hit_i;
					wb_data_o  <= (bus_oe_o && bus_hit_i) ? bus_data_read_i : 32'h0;
					state_q    <= periph_pkg::RESPOND;
				end
				default: begin
					wb_ack_o   <= 1'b0;
					wb_error_o <= 1'b0;
					state_q    <= periph_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

// ==== hw/gpio_block.sv ====
`timescale 1ns/10ps
`include "periph_params.svh"

module gpio_block #(
		parameter logic [7:0] ID = `PERIPH_GPIO_ID
	) (
		input  logic               wb_clk_i,
		input  logic               reset_i,
		input  logic               bus_we_i,
		input  logic               bus_oe_i,
		input  logic [23:0]        bus_address_i,
		input  logic [3:0]         bus_byte_select_i,
		input  logic [31:0]        bus_data_write_i,
		output logic [31:0]        data_read_o,
		output logic               request_output_o,
		input  logic [`IO_PADS-1:0] gpio_input_i,
		output logic [`IO_PADS-1:0] gpio_output_o,
		output logic [`IO_PADS-1:0] gpio_oe_o
	);

	logic [7:0]          offset;
	logic                id_match;
	logic                write_en;
	logic [31:0]         byte_mask;
	logic [`IO_PADS-1:0] wmask;
	logic [`IO_PADS-1:0] wdata;

	assign offset   = bus_address_i[7:0];
	assign id_match = (bus_address_i[23:16] == 8'h00) && (bus_address_i[15:8] == ID);
	assign request_output_o = (bus_we_i || bus_oe_i) && id_match
		&& (offset <= periph_pkg::GPIO_TOGGLE);
	assign write_en = bus_we_i && request_output_o;

	assign byte_mask = {{8{bus_byte_select_i[3]}}, {8{bus_byte_select_i[2]}},
		{8{bus_byte_select_i[1]}}, {8{bus_byte_select_i[0]}}};
	assign wmask = byte_mask[`IO_PADS-1:0];
	assign wdata = bus_data_write_i[`IO_PADS-1:0] & wmask;

	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			gpio_output_o <= '0;
			gpio_oe_o     <= '0;
		end else if (write_en) begin
			case (offset)
				periph_pkg::GPIO_OUT:    gpio_output_o <= (gpio_output_o & ~wmask) | wdata;
				periph_pkg::GPIO_OE:     gpio_oe_o <= (gpio_oe_o & ~wmask) | wdata;
				periph_pkg::GPIO_TOGGLE: gpio_output_o <= gpio_output_o ^ wdata;
				default: ;	// GPIO_IN ignores writes
			endcase
		end
	end

	always_comb begin
		case (offset)
			periph_pkg::GPIO_OUT: data_read_o = {{(32-`IO_PADS){1'b0}}, gpio_output_o};
			periph_pkg::GPIO_OE:  data_read_o = {{(32-`IO_PADS){1'b0}}, gpio_oe_o};
			periph_pkg::GPIO_IN:  data_read_o = {{(32-`IO_PADS){1'b0}}, gpio_input_i};
			default:              data_read_o = 32'h0;
		endcase
	end

endmodule

// ==== hw/pwm_block.sv ====
`timescale 1ns/10ps
`include "periph_params.svh"

module pwm_block #(
		parameter logic [7:0] ID = `PERIPH_PWM_ID
	) (
		input  logic                     wb_clk_i,
		input  logic                     reset_i,
		input  logic                     bus_we_i,
		input  logic                     bus_oe_i,
		input  logic [23:0]              bus_address_i,
		input  logic [3:0]               bus_byte_select_i,
		input  logic [31:0]              bus_data_write_i,
		output logic [31:0]              data_read_o,
		output logic                     request_output_o,
		output logic [`PWM_CHANNELS-1:0] pwm_out_o,
		output logic [`PWM_CHANNELS-1:0] pwm_en_o
	);

	localparam int IDX_W = $clog2(`PWM_CHANNELS);

	logic [7:0]       offset;
	logic             id_match;
	logic             duty_sel;
	logic [IDX_W-1:0] duty_idx;
	logic             write_en;
	logic [7:0]       period_q;
	logic [7:0]       counter_q;
	logic [7:0]       duty_q [`PWM_CHANNELS];

	assign offset   = bus_address_i[7:0];
	assign id_match = (bus_address_i[23:16] == 8'h00) && (bus_address_i[15:8] == ID);
	assign duty_sel = (offset >= periph_pkg::PWM_DUTY0)
		&& (offset < 8'(periph_pkg::PWM_DUTY0 + `PWM_CHANNELS));
	assign duty_idx = IDX_W'(offset - 8'(periph_pkg::PWM_DUTY0));
	assign request_output_o = (bus_we_i || bus_oe_i) && id_match
		&& (offset == periph_pkg::PWM_ENABLE || offset == periph_pkg::PWM_PERIOD || duty_sel);
	assign write_en = bus_we_i && request_output_o && bus_byte_select_i[0];	// All fields in byte 0

	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			pwm_en_o <= '0;
			period_q <= 8'h0;
			for (int k = 0; k < `PWM_CHANNELS; k++) duty_q[k] <= 8'h0;
		end else if (write_en) begin
			if (offset == periph_pkg::PWM_ENABLE) pwm_en_o <= bus_data_write_i[`PWM_CHANNELS-1:0];
			if (offset == periph_pkg::PWM_PERIOD) period_q <= bus_data_write_i[7:0];
			if (duty_sel) duty_q[duty_idx] <= bus_data_write_i[7:0];
		end
	end

	// Shared period counter, wraps after PERIOD
	always_ff @(posedge wb_clk_i) begin
		if (reset_i) counter_q <= 8'h0;
		else if (counter_q >= period_q) counter_q <= 8'h0;	// Also catches a shrunk period
		else counter_q <= counter_q + 8'd1;
	end

	always_comb begin
		for (int k = 0; k < `PWM_CHANNELS; k++) begin
			pwm_out_o[k] = pwm_en_o[k] && (counter_q < duty_q[k]);
		end
	end

	always_comb begin
		if (offset == periph_pkg::PWM_ENABLE)
			data_read_o = {{(32-`PWM_CHANNELS){1'b0}}, pwm_en_o};
		else if (offset == periph_pkg::PWM_PERIOD)
			data_read_o = {24'h0, period_q};
		else if (duty_sel)
			data_read_o = {24'h0, duty_q[duty_idx]};
		else
			data_read_o = 32'h0;
	end

endmodule

// ==== hw/io_mux.sv ====
`timescale 1ns/10ps
`include "periph_params.svh"

module io_mux (
		input  logic                     wb_clk_i,
		input  logic                     reset_i,
		input  logic [`IO_PADS-1:0]      gpio_output_i,
		input  logic [`IO_PADS-1:0]      gpio_oe_i,
		output logic [`IO_PADS-1:0]      gpio_input_o,
		input  logic [`PWM_CHANNELS-1:0] pwm_out_i,
		input  logic [`PWM_CHANNELS-1:0] pwm_en_i,
		input  logic [`IO_PADS-1:0]      io_in_i,
		output logic [`IO_PADS-1:0]      io_out_o,
		output logic [`IO_PADS-1:0]      io_oeb_o
	);

	logic [`IO_PADS-1:0] sync_q;
	logic [`IO_PADS-1:0] pad_out;
	logic [`IO_PADS-1:0] pad_oe;

	// GPIO by default, an enabled PWM channel takes its pad
	always_comb begin
		pad_out = gpio_output_i;
		pad_oe  = gpio_oe_i;
		for (int k = 0; k < `PWM_CHANNELS; k++) begin
			if (pwm_en_i[k]) begin
				pad_out[`PWM_PAD_BASE+k] = pwm_out_i[k];
				pad_oe[`PWM_PAD_BASE+k]  = 1'b1;
			end
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			sync_q       <= '0;
			gpio_input_o <= '0;
			io_out_o     <= '0;
			io_oeb_o     <= '1;	// Pads come up as inputs
		end else begin
			sync_q       <= io_in_i;	// First synchronizer stage
			gpio_input_o <= sync_q;
			io_out_o     <= pad_out;
			io_oeb_o     <= ~pad_oe;
		end
	end

endmodule

// ==== hw/peripherals.sv ====
`timescale 1ns/10ps
`include "periph_params.svh"

module peripherals (
		input  logic                wb_clk_i,
		input  logic                reset_i,
		input  logic                wb_cyc_i,
		input  logic                wb_stb_i,
		input  logic                wb_we_i,
		input  logic [3:0]          wb_sel_i,
		input  logic [23:0]         wb_adr_i,
		input  logic [31:0]         wb_data_i,
		output logic                wb_ack_o,
		output logic                wb_error_o,
		output logic                wb_stall_o,
		output logic [31:0]         wb_data_o,
		input  logic [`IO_PADS-1:0] io_in_i,
		output logic [`IO_PADS-1:0] io_out_o,
		output logic [`IO_PADS-1:0] io_oeb_o
	);

	logic        bus_we;
	logic        bus_oe;
	logic [23:0] bus_address;
	logic [3:0]  bus_byte_select;
	logic [31:0] bus_data_write;
	logic [31:0] bus_data_read;
	logic        bus_hit;

	logic [31:0]              gpio_data_read;
	logic                     gpio_request;
	logic [`IO_PADS-1:0]      gpio_input;
	logic [`IO_PADS-1:0]      gpio_output;
	logic [`IO_PADS-1:0]      gpio_oe;
	logic [31:0]              pwm_data_read;
	logic                     pwm_request;
	logic [`PWM_CHANNELS-1:0] pwm_out;
	logic [`PWM_CHANNELS-1:0] pwm_en;

	wb_periph_bridge bridge (
		.wb_clk_i(wb_clk_i), .reset_i(reset_i),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
		.wb_sel_i(wb_sel_i), .wb_adr_i(wb_adr_i), .wb_data_i(wb_data_i),
		.wb_ack_o(wb_ack_o), .wb_error_o(wb_error_o),
		.wb_stall_o(wb_stall_o), .wb_data_o(wb_data_o),
		.bus_we_o(bus_we), .bus_oe_o(bus_oe), .bus_address_o(bus_address),
		.bus_byte_select_o(bus_byte_select), .bus_data_write_o(bus_data_write),
		.bus_data_read_i(bus_data_read), .bus_hit_i(bus_hit));

	gpio_block #(.ID(`PERIPH_GPIO_ID)) gpio (
		.wb_clk_i(wb_clk_i), .reset_i(reset_i),
		.bus_we_i(bus_we), .bus_oe_i(bus_oe), .bus_address_i(bus_address),
		.bus_byte_select_i(bus_byte_select), .bus_data_write_i(bus_data_write),
		.data_read_o(gpio_data_read), .request_output_o(gpio_request),
		.gpio_input_i(gpio_input), .gpio_output_o(gpio_output), .gpio_oe_o(gpio_oe));

	pwm_block #(.ID(`PERIPH_PWM_ID)) pwm (
		.wb_clk_i(wb_clk_i), .reset_i(reset_i),
		.bus_we_i(bus_we), .bus_oe_i(bus_oe), .bus_address_i(bus_address),
		.bus_byte_select_i(bus_byte_select), .bus_data_write_i(bus_data_write),
		.data_read_o(pwm_data_read), .request_output_o(pwm_request),
		.pwm_out_o(pwm_out), .pwm_en_o(pwm_en));

	io_mux mux (
		.wb_clk_i(wb_clk_i), .reset_i(reset_i),
		.gpio_output_i(gpio_output), .gpio_oe_i(gpio_oe), .gpio_input_o(gpio_input),
		.pwm_out_i(pwm_out), .pwm_en_i(pwm_en),
		.io_in_i(io_in_i), .io_out_o(io_out_o), .io_oeb_o(io_oeb_o));

	assign bus_hit = pwm_request | gpio_request;

	// First claiming block wins
	always_comb begin
		case (1'b1)
			pwm_request:  bus_data_read = pwm_data_read;
			gpio_request: bus_data_read = gpio_data_read;
			default:      bus_data_read = 32'h0;
		endcase
	end

endmodule

// ==== bench/periph_chk.sv ====
`timescale 1ns/10ps
`include "periph_params.svh"

module periph_chk (
		input logic                wb_clk_i,
		input logic                reset_i,
		input logic                wb_cyc_i,
		input logic                wb_stb_i,
		input logic                wb_ack_i,
		input logic                wb_error_i,
		input logic                wb_stall_i,
		input logic [`IO_PADS-1:0] io_out_i,
		input logic [`IO_PADS-1:0] io_oeb_i
	);

	logic accept;
	logic response;
	logic pending_q;
	int   failures = 0;

	assign accept   = wb_cyc_i && wb_stb_i && !wb_stall_i;
	assign response = wb_ack_i || wb_error_i;

	// Request accepted and not yet answered
	always_ff @(posedge wb_clk_i) begin
		if (reset_i) pending_q <= 1'b0;
		else if (accept) pending_q <= 1'b1;
		else if (response) pending_q <= 1'b0;
	end

	ack_error_exclusive: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		!(wb_ack_i && wb_error_i))
		else begin failures++; $error("ack and error high in the same cycle"); end

	response_latency: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		response == $past(accept, 2))
		else begin failures++; $error("Response not exactly two cycles after acceptance"); end

	stall_while_pending: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		(pending_q || response) |-> wb_stall_i)
		else begin failures++; $error("Stall low while a response is pending"); end

	pads_reset: assert property (@(posedge wb_clk_i)
		reset_i |=> (io_oeb_i == '1 && io_out_i == '0))
		else begin failures++; $error("Pads not inputs and low after reset"); end

endmodule

bind peripherals periph_chk u_chk (
	.wb_clk_i(wb_clk_i), .reset_i(reset_i),
	.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
	.wb_ack_i(wb_ack_o), .wb_error_i(wb_error_o), .wb_stall_i(wb_stall_o),
	.io_out_i(io_out_o), .io_oeb_i(io_oeb_o));

// ==== bench/periph_scoreboard.sv ====
`timescale 1ns/10ps
`include "periph_params.svh"

module periph_scoreboard (
		input logic                wb_clk_i,
		input logic                wb_ack_i,
		input logic                wb_error_i,
		input logic [31:0]         wb_data_i,
		input logic [`IO_PADS-1:0] io_out_i,
		input logic [`IO_PADS-1:0] io_oeb_i
	);

	int checks = 0;
	int errors = 0;

	function automatic void compare(input string name, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail %s %s: expected %h, actual %h", name, what, expected, actual);
		end
	endfunction

	function automatic void note_failure(input string what);
		errors++;
		$display("%s", what);
	endfunction

	// Called in the response cycle, A means ack and anything else means error
	function automatic void check_response(input string name, input logic is_read,
			input byte exp_resp, input logic [31:0] exp_data);
		logic exp_ack;
		exp_ack = (exp_resp == "A");
		compare(name, "ack", {31'h0, exp_ack}, {31'h0, wb_ack_i});
		compare(name, "error", {31'h0, !exp_ack}, {31'h0, wb_error_i});
		if (is_read && exp_ack) compare(name, "read data", exp_data, wb_data_i);
	endfunction

	function automatic void check_pads(input string name, input logic [`IO_PADS-1:0] exp_out,
			input logic [`IO_PADS-1:0] exp_oeb);
		compare(name, "io_out", 32'(exp_out), 32'(io_out_i));
		compare(name, "io_oeb", 32'(exp_oeb), 32'(io_oeb_i));
	endfunction

	// Any window of PERIOD+1 cycles holds one full period of the channel
	task automatic measure_pwm(input string name, input int channel, input int window,
			input int exp_high);
		int pad;
		int high;
		int out_cycles;
		pad        = `PWM_PAD_BASE + channel;
		high       = 0;
		out_cycles = 0;
		repeat (window) begin
			@(negedge wb_clk_i);
			if (io_out_i[pad]) high++;
			if (!io_oeb_i[pad]) out_cycles++;	// Pad must stay an output
		end
		compare(name, "high cycles", exp_high, high);
		compare(name, "output cycles", window, out_cycles);
	endtask

endmodule

// ==== bench/tb_peripherals.sv ====
`timescale 1ns/10ps
`include "periph_params.svh"

module tb_peripherals;

	localparam int ACCEPT_TIMEOUT   = 40;
	localparam int RESPONSE_TIMEOUT = 40;

	logic                clk;
	logic                reset;
	logic                wb_cyc;
	logic                wb_stb;
	logic                wb_we;
	logic [3:0]          wb_sel;
	logic [23:0]         wb_adr;
	logic [31:0]         wb_data;
	logic                wb_ack;
	logic                wb_error;
	logic                wb_stall;
	logic [31:0]         wb_rdata;
	logic [`IO_PADS-1:0] io_in;
	logic [`IO_PADS-1:0] io_out;
	logic [`IO_PADS-1:0] io_oeb;
	logic                abort_run;

	peripherals u_peripherals (
		.wb_clk_i(clk), .reset_i(reset),
		.wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
		.wb_sel_i(wb_sel), .wb_adr_i(wb_adr), .wb_data_i(wb_data),
		.wb_ack_o(wb_ack), .wb_error_o(wb_error),
		.wb_stall_o(wb_stall), .wb_data_o(wb_rdata),
		.io_in_i(io_in), .io_out_o(io_out), .io_oeb_o(io_oeb));

	periph_scoreboard u_sb (
		.wb_clk_i(clk), .wb_ack_i(wb_ack), .wb_error_i(wb_error),
		.wb_data_i(wb_rdata), .io_out_i(io_out), .io_oeb_i(io_oeb));

	always #2 clk = ~clk;	// 4 ns period

	task automatic check_fields(input int got, input int want, input byte op);
		if (got != want) begin
			u_sb.note_failure($sformatf("Malformed %c line in the data file", op));
			abort_run = 1'b1;
		end
	endtask

	// One Wishbone request, waits for acceptance and then for ack or error
	task automatic bus_access(input string name, input logic is_write, input logic [23:0] adr,
			input logic [31:0] data, input logic [3:0] sel, input byte exp_resp,
			input logic [31:0] exp_data);
		int waited;
		waited = 0;
		@(posedge clk);
		wb_cyc  <= 1'b1;
		wb_stb  <= 1'b1;
		wb_we   <= is_write;
		wb_adr  <= adr;
		wb_data <= data;
		wb_sel  <= sel;
		@(negedge clk);
		while (wb_stall && waited < ACCEPT_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (wb_stall) begin
			u_sb.note_failure($sformatf("%s: request never accepted, stall stuck high", name));
			abort_run = 1'b1;
		end else begin
			@(posedge clk);	// Accepted here
			wb_stb <= 1'b0;
			waited = 0;
			@(negedge clk);
			while (!(wb_ack || wb_error) && waited < RESPONSE_TIMEOUT) begin
				@(negedge clk);
				waited++;
			end
			if (wb_ack || wb_error) begin
				u_sb.check_response(name, !is_write, exp_resp, exp_data);
			end else begin
				u_sb.note_failure($sformatf("%s: neither ack nor error came back", name));
				abort_run = 1'b1;
			end
		end
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	initial begin
		int          fd;
		int          n;
		byte         op;
		byte         resp;
		string       name;
		string       skip;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		int          ch;
		int          window;
		int          high;
		clk       = 1'b0;
		reset     = 1'b1;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_sel    = 4'h0;
		wb_adr    = 24'h0;
		wb_data   = 32'h0;
		io_in     = '0;
		abort_run = 1'b0;
		fd = $fopen("bench/periph_testdata.txt", "r");
		if (fd == 0) begin
			u_sb.note_failure("Could not open bench/periph_testdata.txt");
		end else begin
			repeat (4) @(posedge clk);
			reset <= 1'b0;
			while (!abort_run && $fscanf(fd, " %c", op) == 1) begin
				case (op)
					"#": n = $fgets(skip, fd);
					"W": begin
						n = $fscanf(fd, "%s %h %h %h %c", name, f1, f2, f3, resp);
						check_fields(n, 5, op);
						if (!abort_run) bus_access(name, 1'b1, f1[23:0], f2, f3[3:0], resp, 32'h0);
					end
					"R": begin
						n = $fscanf(fd, "%s %h %h %c", name, f1, f2, resp);
						check_fields(n, 4, op);
						if (!abort_run) bus_access(name, 1'b0, f1[23:0], 32'h0, 4'hf, resp, f2);
					end
					"I": begin
						n = $fscanf(fd, "%s %h", name, f1);
						check_fields(n, 2, op);
						@(posedge clk);
						io_in <= f1[`IO_PADS-1:0];
					end
					"O": begin
						n = $fscanf(fd, "%s %h %h", name, f1, f2);
						check_fields(n, 3, op);
						repeat (3) @(posedge clk);
						@(negedge clk);
						u_sb.check_pads(name, f1[`IO_PADS-1:0], f2[`IO_PADS-1:0]);
					end
					"M": begin
						n = $fscanf(fd, "%s %d %d %d", name, ch, window, high);
						check_fields(n, 4, op);
						if (!abort_run) u_sb.measure_pwm(name, ch, window, high);
					end
					default: begin
						u_sb.note_failure($sformatf("Unknown operation %c in the data file", op));
						abort_run = 1'b1;
					end
				endcase
			end
			$fclose(fd);
		end
		repeat (2) @(posedge clk);
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			u_sb.checks, u_sb.errors, u_peripherals.u_chk.failures);
		if (u_sb.errors == 0 && u_peripherals.u_chk.failures == 0 && !abort_run)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// ==== bench/periph_testdata.txt ====
# W name addr data sel resp, R name addr data resp, I name io_in (all hex)
# O name io_out io_oeb (hex), M name channel window high_cycles (decimal)
W gpio_out_full   000300 1234a5c3 f A
W gpio_out_byte1  000300 00003c5a 2 A
W gpio_out_byte0  000300 00ff9911 5 A
R gpio_out_merge  000300 00003c11 A
W gpio_oe_low     000301 00000f0f 3 A
W gpio_oe_byte0   000301 0000aaff 1 A
R gpio_oe_merge   000301 00000fff A
W gpio_toggle_lo  000303 00000f0f 3 A
R gpio_toggle_rd  000303 00000000 A
R gpio_toggle_lo  000300 0000331e A
W gpio_toggle_hi  000303 0000ffff 2 A
O pads_toggle     cc1e f000
I pad_input       5a3c
O pads_input      cc1e f000
R gpio_in         000302 00005a3c A
R bad_id          000500 00000000 E
W bad_upper       010300 0000ffff f E
W bad_offset      000304 0000ffff f E
R bad_pwm_offset  000206 00000000 E
R kept_out        000300 0000cc1e A
W pwm_period      000201 00000009 1 A
R pwm_period      000201 00000009 A
W pwm_duty0       000202 00000004 1 A
W pwm_duty1       000203 0000000c 1 A
W pwm_duty3       000205 00000007 1 A
R pwm_duty1       000203 0000000c A
W pwm_enable      000200 000000fb 1 A
R pwm_enable      000200 0000000b A
M pwm_ch0         0 10 4
M pwm_ch1         1 10 10
M pwm_ch3         3 10 7
W pwm_disable     000200 00000000 1 A
O pads_gpio_again cc1e f000

// ==== compile.f ====
+incdir+hw
hw/periph_pkg.sv
hw/wb_periph_bridge.sv
hw/gpio_block.sv
hw/pwm_block.sv
hw/io_mux.sv
hw/peripherals.sv
bench/periph_chk.sv
bench/periph_scoreboard.sv
bench/tb_peripherals.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_peripherals
RTL_TOP   ?= peripherals
FILELIST  ?= compile.f
RTL_FILES ?= hw/periph_pkg.sv hw/wb_periph_bridge.sv hw/gpio_block.sv hw/pwm_block.sv \
	hw/io_mux.sv hw/peripherals.sv
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only +incdir+hw $(RTL_FILES) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
